//--- sources.f
+incdir+verilog
verilog/mtimer_pkg.sv
verilog/mtimer_port_arbiter.sv
verilog/mtimer_regfile.sv
verilog/mtimer_top.sv
dv/mtimer_asserts.sv
dv/mtimer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the machine timer testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=build
LOG=sim.log

rm -rf "$BUILD_DIR"
verilator --binary --timing --assert -Wno-fatal \
  --top-module mtimer_tb -Mdir "$BUILD_DIR" -f sources.f

"./$BUILD_DIR/Vmtimer_tb" | tee "$LOG"

if grep -qx "sim failed" "$LOG"; then
  echo "Simulation reported failure, see $LOG"
  exit 1
fi
if ! grep -qx "sim passed" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi
echo "Simulation clean"

//--- dv/mtimer_tb.sv
`timescale 1ns/1ps
`include "mtimer_config.svh"

module mtimer_tb;

  import mtimer_pkg::*;

  localparam int NH        = `MTIMER_NUM_HARTS;
  localparam int AW        = `MTIMER_ADDR_W;
  localparam int DW        = `MTIMER_DATA_W;
  localparam int ACK_LIMIT = 64;
  localparam int N_BURST   = 32;

  logic          i_aclk;
  logic          i_rst;
  logic          i_mtime_tick;
  logic [NH-1:0] i_stoptime;
  logic          i_p0_req;
  reg_req_t      i_p0_cmd;
  logic          o_p0_ack;
  reg_rsp_t      o_p0_rsp;
  logic          i_p1_req;
  reg_req_t      i_p1_cmd;
  logic          o_p1_ack;
  reg_rsp_t      o_p1_rsp;
  logic [NH-1:0] o_mtip;

  // Reference model of the timer registers
  logic [DW-1:0] model_mtime;
  logic [DW-1:0] model_cmp [NH];

  reg_req_t    pend_cmd [2];
  logic [1:0]  prev_ack;
  logic [1:0]  req_seen;
  int          mtip_due [2];
  int          issued [2];
  int          done_cnt [2];
  int          last_port;
  bit          last_other_req;
  int          contended;
  int          checks;
  int          errors;
  int          timeouts;
  logic [31:0] rng_state;
  reg_req_t    burst_cmd [2][N_BURST];
  int          burst_gap [2][N_BURST];

  mtimer_top dut_i (
    .i_aclk       (i_aclk),
    .i_rst        (i_rst),
    .i_mtime_tick (i_mtime_tick),
    .i_stoptime   (i_stoptime),
    .i_p0_req     (i_p0_req),
    .i_p0_cmd     (i_p0_cmd),
    .o_p0_ack     (o_p0_ack),
    .o_p0_rsp     (o_p0_rsp),
    .i_p1_req     (i_p1_req),
    .i_p1_cmd     (i_p1_cmd),
    .o_p1_ack     (o_p1_ack),
    .o_p1_rsp     (o_p1_rsp),
    .o_mtip       (o_mtip)
  );

  initial begin
    i_aclk = 1'b0;
    forever #2 i_aclk = ~i_aclk;
  end

  // ***********************************************************
  // Random numbers and reference model
  // ***********************************************************

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic int pick_port();
    return int'(next_rand() & 32'd1);
  endfunction

  // Index 0 is mtime, index h + 1 is mtimecmp of hart h
  function automatic logic [AW-1:0] reg_addr(input int idx);
    return AW'(8 * idx);
  endfunction

  // -1 when unmapped or unaligned
  function automatic int reg_index(input logic [AW-1:0] addr);
    int idx;
    idx = -1;
    if (addr == 12'h000) begin
      idx = 0;
    end else if (addr[2:0] == 3'b000 && addr >= 12'h008 && int'(addr) < 8 + 8 * NH) begin
      idx = int'(addr >> 3);
    end
    return idx;
  endfunction

  function automatic reg_rsp_t expected_rsp(input reg_req_t c);
    reg_rsp_t e;
    int       idx;
    idx     = reg_index(c.addr);
    e.rdata = '0;
    e.err   = (idx < 0);
    if (!c.wr && idx == 0) begin
      e.rdata = model_mtime;
    end else if (!c.wr && idx > 0) begin
      e.rdata = model_cmp[idx-1];
    end
    return e;
  endfunction

  function automatic logic [NH-1:0] expected_mtip();
    logic [NH-1:0] m;
    for (int h = 0; h < NH; h++) begin
      m[h] = (model_mtime >= model_cmp[h]);
    end
    return m;
  endfunction

  function automatic logic [AW-1:0] bad_addr(input logic [15:0] r);
    logic [AW-1:0] a;
    if (r[0]) begin
      // Inside the map, off an 8-byte boundary
      a      = AW'(8 * (int'(r[6:4]) % (NH + 1)));
      a[2:0] = (r[3:1] == 3'd0) ? 3'd4 : r[3:1];
    end else begin
      a = AW'(8 * (NH + 1) + 8 * int'(r[11:4]));
    end
    return a;
  endfunction

  function automatic reg_req_t random_cmd(input bit allow_bad);
    reg_req_t    c;
    logic [31:0] r;
    r       = next_rand();
    c.wr    = r[0];
    c.wdata = {next_rand(), next_rand()};
    c.addr  = reg_addr(int'(r[15:8]) % (NH + 1));
    if (allow_bad && r[3:1] == 3'd0) begin
      c.addr = bad_addr(r[31:16]);
    end
    return c;
  endfunction

  // ***********************************************************
  // Port driving
  // ***********************************************************

  function automatic logic port_ack(input int port);
    return (port == 0) ? o_p0_ack : o_p1_ack;
  endfunction

  task automatic drive_port(input int port, input logic req, input reg_req_t cmd);
    if (port == 0) begin
      i_p0_req = req;
      i_p0_cmd = cmd;
    end else begin
      i_p1_req = req;
      i_p1_cmd = cmd;
    end
  endtask

  task finish_run();
    $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  task automatic check_mtip();
    logic [NH-1:0] exp;
    exp = expected_mtip();
    checks++;
    if (o_mtip !== exp) begin
      errors++;
      $display("Fail %0t: o_mtip 0x%0h, expected 0x%0h", $time, o_mtip, exp);
    end
  endtask

  // Full four-phase cycle, then two idle cycles
  task automatic port_access(input int port, input reg_req_t cmd);
    int n;
    @(negedge i_aclk);
    pend_cmd[port] = cmd;
    drive_port(port, 1'b1, cmd);
    issued[port]++;
    n = 0;
    while (!port_ack(port) && n < ACK_LIMIT) begin
      @(negedge i_aclk);
      n++;
    end
    if (!port_ack(port)) begin
      $display("timeout waiting for ack on port %0d", port);
      timeouts++;
      drive_port(port, 1'b0, cmd);
    end else begin
      drive_port(port, 1'b0, cmd);
      n = 0;
      while (port_ack(port) && n < ACK_LIMIT) begin
        @(negedge i_aclk);
        n++;
      end
      if (port_ack(port)) begin
        $display("timeout waiting for ack to drop on port %0d", port);
        timeouts++;
      end else begin
        repeat (2) @(negedge i_aclk);
      end
    end
  endtask

  task automatic read_reg(input int port, input logic [AW-1:0] addr);
    reg_req_t c;
    c.wr    = 1'b0;
    c.addr  = addr;
    c.wdata = '0;
    port_access(port, c);
  endtask

  task automatic write_reg(input int port, input logic [AW-1:0] addr, input logic [DW-1:0] d);
    reg_req_t c;
    c.wr    = 1'b1;
    c.addr  = addr;
    c.wdata = d;
    port_access(port, c);
  endtask

  task automatic run_burst(input int port);
    for (int i = 0; i < N_BURST; i++) begin
      repeat (burst_gap[port][i]) @(negedge i_aclk);
      port_access(port, burst_cmd[port][i]);
    end
  endtask

  // ***********************************************************
  // Response checking
  // ***********************************************************

  always @(posedge i_aclk) begin
    req_seen <= {i_p1_req, i_p0_req};
  end

  task automatic check_response(input int p);
    reg_rsp_t got;
    reg_rsp_t exp;
    int       idx;
    got = (p == 0) ? o_p0_rsp : o_p1_rsp;
    exp = expected_rsp(pend_cmd[p]);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t: port %0d addr 0x%03h got 0x%016h err %0b, expected 0x%016h err %0b",
               $time, p, pend_cmd[p].addr, got.rdata, got.err, exp.rdata, exp.err);
    end
    idx = reg_index(pend_cmd[p].addr);
    if (pend_cmd[p].wr && idx == 0) begin
      model_mtime = pend_cmd[p].wdata;
    end else if (pend_cmd[p].wr && idx > 0) begin
      model_cmp[idx-1] = pend_cmd[p].wdata;
    end
    // A waiting peer must win the next grant
    checks++;
    if (last_port == p && last_other_req) begin
      errors++;
      $display("Fail %0t: port %0d granted twice while port %0d waited", $time, p, 1 - p);
    end
    if (req_seen[1-p]) begin
      contended++;
    end
    last_other_req = req_seen[1-p];
    last_port      = p;
    done_cnt[p]++;
  endtask

  // Responses update the model before the mtip compare of the same cycle
  always @(negedge i_aclk) begin
    if (i_rst) begin
      prev_ack    = 2'b00;
      mtip_due[0] = 0;
      mtip_due[1] = 0;
    end else begin
      if (o_p0_ack && !prev_ack[0]) begin
        check_response(0);
      end
      if (o_p1_ack && !prev_ack[1]) begin
        check_response(1);
      end
      // Compare mtip two cycles after a port ack falls
      for (int p = 0; p < 2; p++) begin
        if (mtip_due[p] > 0) begin
          mtip_due[p]--;
          if (mtip_due[p] == 0) begin
            check_mtip();
          end
        end
        if (prev_ack[p] && !port_ack(p)) begin
          mtip_due[p] = 2;
        end
      end
      prev_ack = {o_p1_ack, o_p0_ack};
    end
  end

  // ***********************************************************
  // Test sequence
  // ***********************************************************

  initial begin
    logic [31:0]   r;
    logic [DW-1:0] base;
    logic [DW-1:0] val;
    reg_req_t      c;
    rng_state      = 32'd60;
    model_mtime    = '0;
    last_port      = -1;
    last_other_req = 1'b0;
    contended      = 0;
    checks         = 0;
    errors         = 0;
    timeouts       = 0;
    for (int h = 0; h < NH; h++) begin
      model_cmp[h] = '1;
    end
    for (int p = 0; p < 2; p++) begin
      issued[p]   = 0;
      done_cnt[p] = 0;
    end
    i_rst        = 1'b1;
    i_mtime_tick = 1'b0;
    i_stoptime   = '0;
    drive_port(0, 1'b0, '0);
    drive_port(1, 1'b0, '0);
    repeat (10) @(posedge i_aclk);
    @(negedge i_aclk);
    i_rst = 1'b0;

    // Reset values
    for (int i = 0; i <= NH; i++) begin
      read_reg(pick_port(), reg_addr(i));
    end

    // Counting under random stoptime
    for (int i = 0; i < 240; i++) begin
      @(negedge i_aclk);
      r            = next_rand();
      i_mtime_tick = r[0];
      i_stoptime   = (r[2:1] == 2'b00) ? '1 : r[8+NH-1:8];
      if (i_mtime_tick && !(&i_stoptime)) begin
        model_mtime = model_mtime + 1'b1;
      end
    end
    @(negedge i_aclk);
    i_mtime_tick = 1'b0;
    read_reg(pick_port(), reg_addr(0));

    // Compare values on both sides of mtime
    r    = next_rand();
    base = {2'b01, r[29:0], next_rand()};
    write_reg(pick_port(), reg_addr(0), base);
    for (int h = 0; h < NH; h++) begin
      r   = next_rand();
      val = (h % 2 == 0) ? base - 64'(r[7:0]) - 1 : base + 64'(r[7:0]) + 1;
      write_reg(pick_port(), reg_addr(h + 1), val);
    end
    for (int i = 0; i <= NH; i++) begin
      read_reg(pick_port(), reg_addr(i));
    end
    write_reg(pick_port(), reg_addr(0), base + 64'h1000);
    write_reg(pick_port(), reg_addr(0), base - 64'h1000);
    // Equal counts as expired
    write_reg(pick_port(), reg_addr(1), base - 64'h1000);
    read_reg(pick_port(), reg_addr(1));

    // Unmapped and unaligned accesses
    for (int i = 0; i < 24; i++) begin
      r       = next_rand();
      c.wr    = r[31];
      c.addr  = bad_addr(r[15:0]);
      c.wdata = {next_rand(), next_rand()};
      port_access(pick_port(), c);
    end
    for (int i = 0; i <= NH; i++) begin
      read_reg(pick_port(), reg_addr(i));
    end

    // Both ports at once
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < N_BURST; i++) begin
        burst_cmd[p][i] = random_cmd(1'b1);
        burst_gap[p][i] = int'(next_rand() % 3);
      end
    end
    contended = 0;
    fork
      run_burst(0);
      run_burst(1);
    join
    // Let the last mtip compare run
    @(negedge i_aclk);
    for (int p = 0; p < 2; p++) begin
      checks++;
      if (done_cnt[p] != issued[p]) begin
        errors++;
        $display("Fail %0t: port %0d completed %0d of %0d accesses",
                 $time, p, done_cnt[p], issued[p]);
      end
    end
    checks++;
    if (contended == 0) begin
      errors++;
      $display("Fail %0t: no overlapping requests seen", $time);
    end
    finish_run();
  end

endmodule

//--- dv/mtimer_asserts.sv
`timescale 1ns/1ps

module mtimer_asserts (
  input wire                  i_aclk,
  input wire                  i_rst,
  input logic                 i_p0_req,
  input mtimer_pkg::reg_req_t i_p0_cmd,
  input logic                 i_p0_ack,
  input logic                 i_p1_req,
  input mtimer_pkg::reg_req_t i_p1_cmd,
  input logic                 i_p1_ack,
  input logic                 i_bus_req,
  input mtimer_pkg::reg_req_t i_bus_cmd,
  input logic                 i_bus_ack
);

  // ***********************************************************
  // Four-phase rules on both ports and the internal bus
  // ***********************************************************

  p0_ack_needs_req: assert property (@(posedge i_aclk) disable iff (i_rst)
    $rose(i_p0_ack) |-> $past(i_p0_req)) else $error("port 0 ack rose without req");
  p1_ack_needs_req: assert property (@(posedge i_aclk) disable iff (i_rst)
    $rose(i_p1_ack) |-> $past(i_p1_req)) else $error("port 1 ack rose without req");
  bus_ack_needs_req: assert property (@(posedge i_aclk) disable iff (i_rst)
    $rose(i_bus_ack) |-> $past(i_bus_req)) else $error("bus ack rose without req");

  p0_cmd_stable: assert property (@(posedge i_aclk) disable iff (i_rst)
    i_p0_req && $past(i_p0_req) |-> $stable(i_p0_cmd)) else $error("port 0 cmd changed");
  p1_cmd_stable: assert property (@(posedge i_aclk) disable iff (i_rst)
    i_p1_req && $past(i_p1_req) |-> $stable(i_p1_cmd)) else $error("port 1 cmd changed");
  bus_cmd_stable: assert property (@(posedge i_aclk) disable iff (i_rst)
    i_bus_req && $past(i_bus_req) |-> $stable(i_bus_cmd)) else $error("bus cmd changed");

  p0_ack_held: assert property (@(posedge i_aclk) disable iff (i_rst)
    i_p0_ack && i_p0_req |=> i_p0_ack) else $error("port 0 ack dropped early");
  p1_ack_held: assert property (@(posedge i_aclk) disable iff (i_rst)
    i_p1_ack && i_p1_req |=> i_p1_ack) else $error("port 1 ack dropped early");
  bus_ack_held: assert property (@(posedge i_aclk) disable iff (i_rst)
    i_bus_ack && i_bus_req |=> i_bus_ack) else $error("bus ack dropped early");

  // One winner at a time
  one_port_ack: assert property (@(posedge i_aclk) disable iff (i_rst)
    !(i_p0_ack && i_p1_ack)) else $error("both port acks high");

endmodule

bind mtimer_top mtimer_asserts u_asserts (
  .i_aclk    (i_aclk),
  .i_rst     (i_rst),
  .i_p0_req  (i_p0_req),
  .i_p0_cmd  (i_p0_cmd),
  .i_p0_ack  (o_p0_ack),
  .i_p1_req  (i_p1_req),
  .i_p1_cmd  (i_p1_cmd),
  .i_p1_ack  (o_p1_ack),
  .i_bus_req (bus_req),
  .i_bus_cmd (bus_cmd),
  .i_bus_ack (bus_ack)
);

//--- verilog/mtimer_top.sv
`timescale 1ns/1ps
`include "mtimer_config.svh"

module mtimer_top (
  input  wire                          i_aclk,
  input  wire                          i_rst,
  input  logic                         i_mtime_tick,
  input  logic [`MTIMER_NUM_HARTS-1:0] i_stoptime,
  // Hart-side port
  input  logic                         i_p0_req,
  input  mtimer_pkg::reg_req_t         i_p0_cmd,
  output logic                         o_p0_ack,
  output mtimer_pkg::reg_rsp_t         o_p0_rsp,
  // System port for debug and boot
  input  logic                         i_p1_req,
  input  mtimer_pkg::reg_req_t         i_p1_cmd,
  output logic                         o_p1_ack,
  output mtimer_pkg::reg_rsp_t         o_p1_rsp,
  output logic [`MTIMER_NUM_HARTS-1:0] o_mtip
);

  import mtimer_pkg::*;

  // Arbiter to register file
  logic     bus_req;
  reg_req_t bus_cmd;
  logic     bus_ack;
  reg_rsp_t bus_rsp;

  mtimer_port_arbiter u_arb (
    .i_aclk    (i_aclk),
    .i_rst     (i_rst),
    .i_p0_req  (i_p0_req),
    .i_p0_cmd  (i_p0_cmd),
    .o_p0_ack  (o_p0_ack),
    .o_p0_rsp  (o_p0_rsp),
    .i_p1_req  (i_p1_req),
    .i_p1_cmd  (i_p1_cmd),
    .o_p1_ack  (o_p1_ack),
    .o_p1_rsp  (o_p1_rsp),
    .o_bus_req (bus_req),
    .o_bus_cmd (bus_cmd),
    .i_bus_ack (bus_ack),
    .i_bus_rsp (bus_rsp)
  );

  mtimer_regfile u_regs (
    .i_aclk       (i_aclk),
    .i_rst        (i_rst),
    .i_mtime_tick (i_mtime_tick),
    .i_stoptime   (i_stoptime),
    .i_bus_req    (bus_req),
    .i_bus_cmd    (bus_cmd),
    .o_bus_ack    (bus_ack),
    .o_bus_rsp    (bus_rsp),
    .o_mtip       (o_mtip)
  );

endmodule

//--- verilog/mtimer_regfile.sv
`timescale 1ns/1ps
`include "mtimer_config.svh"

module mtimer_regfile (
  input  wire                          i_aclk,
  input  wire                          i_rst,
  input  logic                         i_mtime_tick,
  input  logic [`MTIMER_NUM_HARTS-1:0] i_stoptime,
  input  logic                         i_bus_req,
  input  mtimer_pkg::reg_req_t         i_bus_cmd,
  output logic                         o_bus_ack,
  output mtimer_pkg::reg_rsp_t         o_bus_rsp,
  output logic [`MTIMER_NUM_HARTS-1:0] o_mtip
);

  import mtimer_pkg::*;

  localparam int unsigned NH = `MTIMER_NUM_HARTS;
  localparam int unsigned AW = `MTIMER_ADDR_W;
  localparam int unsigned DW = `MTIMER_DATA_W;
  localparam int unsigned HW = (NH > 1) ? $clog2(NH) : 1;

  logic [DW-1:0] mtime;
  logic [DW-1:0] mtimecmp [NH];

  logic          access;
  logic          stop_all;
  logic          hit_mtime;
  logic          hit_cmp;
  logic [AW-1:0] cmp_off;
  logic [AW-4:0] cmp_slot;
  logic [HW-1:0] cmp_idx;
  logic [DW-1:0] rd_data;

  // New request seen, ack not yet raised
  assign access   = i_bus_req && !o_bus_ack;
  // Counter halts only when every hart asks for it
  assign stop_all = &i_stoptime;

  // ***********************************************************
  // Address decode
  // ***********************************************************

  always_comb begin
    cmp_off   = i_bus_cmd.addr - MTIMECMP_BASE;
    cmp_slot  = cmp_off[AW-1:3];
    cmp_idx   = cmp_slot[HW-1:0];
    hit_mtime = (i_bus_cmd.addr == MTIME_OFFSET);
    hit_cmp   = (i_bus_cmd.addr[2:0] == 3'b000) &&
                (i_bus_cmd.addr >= MTIMECMP_BASE) &&
                (cmp_slot < NH);
  end

  // Writes and errors return zero data
  always_comb begin
    rd_data = '0;
    if (!i_bus_cmd.wr) begin
      if (hit_mtime) begin
        rd_data = mtime;
      end else if (hit_cmp) begin
        rd_data = mtimecmp[cmp_idx];
      end
    end
  end

  // ***********************************************************
  // Timer state
  // ***********************************************************

  // Software write wins over a tick
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      mtime <= '0;
    end else if (access && i_bus_cmd.wr && hit_mtime) begin
      mtime <= i_bus_cmd.wdata;
    end else if (i_mtime_tick && !stop_all) begin
      mtime <= mtime + 1'b1;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      for (int h = 0; h < NH; h++) begin
        mtimecmp[h] <= '1;
      end
    end else if (access && i_bus_cmd.wr && hit_cmp) begin
      mtimecmp[cmp_idx] <= i_bus_cmd.wdata;
    end
  end

  // One cycle behind the counter and compare values
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      o_mtip <= '0;
    end else begin
      for (int h = 0; h < NH; h++) begin
        o_mtip[h] <= (mtime >= mtimecmp[h]);
      end
    end
  end

  // ***********************************************************
  // Bus handshake
  // ***********************************************************

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      o_bus_ack <= 1'b0;
    end else if (access) begin
      o_bus_ack <= 1'b1;
    end else if (!i_bus_req) begin
      o_bus_ack <= 1'b0;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (access) begin
      o_bus_rsp.rdata <= rd_data;
      o_bus_rsp.err   <= !(hit_mtime || hit_cmp);
    end
  end

endmodule

//--- verilog/mtimer_port_arbiter.sv
`timescale 1ns/1ps
`include "mtimer_config.svh"

module mtimer_port_arbiter (
  input  wire                  i_aclk,
  input  wire                  i_rst,
  input  logic                 i_p0_req,
  input  mtimer_pkg::reg_req_t i_p0_cmd,
  output logic                 o_p0_ack,
  output mtimer_pkg::reg_rsp_t o_p0_rsp,
  input  logic                 i_p1_req,
  input  mtimer_pkg::reg_req_t i_p1_cmd,
  output logic                 o_p1_ack,
  output mtimer_pkg::reg_rsp_t o_p1_rsp,
  output logic                 o_bus_req,
  output mtimer_pkg::reg_req_t o_bus_cmd,
  input  logic                 i_bus_ack,
  input  mtimer_pkg::reg_rsp_t i_bus_rsp
);

  import mtimer_pkg::*;

  localparam int unsigned NP = `MTIMER_NUM_PORTS;
  localparam int unsigned PW = $clog2(NP);

  typedef enum logic [1:0] {ST_IDLE, ST_FWD, ST_ACK, ST_REL} arb_state_t;

  arb_state_t    state;
  logic [PW-1:0] grant;
  logic [PW-1:0] last;
  logic [PW-1:0] pick;
  logic [NP-1:0] req;
  logic [NP-1:0] ack;
  reg_req_t      cmd [NP];
  reg_rsp_t      rsp [NP];

  assign req    = {i_p1_req, i_p0_req};
  assign cmd[0] = i_p0_cmd;
  assign cmd[1] = i_p1_cmd;

  assign o_p0_ack = ack[0];
  assign o_p1_ack = ack[1];
  assign o_p0_rsp = rsp[0];
  assign o_p1_rsp = rsp[1];

  // Search starts just after the last winner, so it has lowest priority
  always_comb begin
    int unsigned nxt;
    pick = last;
    for (int k = NP; k >= 1; k--) begin
      nxt = (int'(last) + k) % NP;
      if (req[nxt]) begin
        pick = nxt[PW-1:0];
      end
    end
  end

  // ***********************************************************
  // Grant FSM
  // ***********************************************************

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      state     <= ST_IDLE;
      grant     <= '0;
      last      <= PW'(NP - 1);
      o_bus_req <= 1'b0;
      ack       <= '0;
    end else begin
      case (state)
        ST_IDLE: if (|req) begin
          grant     <= pick;
          o_bus_req <= 1'b1;
          state     <= ST_FWD;
        end
        // Bus handshake closes while the port ack goes out
        ST_FWD: if (i_bus_ack) begin
          o_bus_req  <= 1'b0;
          ack[grant] <= 1'b1;
          state      <= ST_ACK;
        end
        ST_ACK: if (!req[grant]) begin
          ack[grant] <= 1'b0;
          state      <= ST_REL;
        end
        // Wait for the register file to drop its ack
        ST_REL: if (!i_bus_ack) begin
          last  <= grant;
          state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (state == ST_IDLE && |req) begin
      o_bus_cmd <= cmd[pick];
    end
    if (state == ST_FWD && i_bus_ack) begin
      rsp[grant] <= i_bus_rsp;
    end
  end

endmodule

//--- verilog/mtimer_pkg.sv
`include "mtimer_config.svh"

package mtimer_pkg;

  // ***********************************************************
  // Register bus payloads
  // ***********************************************************

  // One access, 1 + 12 + 64 bits
  typedef struct packed {
    logic                      wr;
    logic [`MTIMER_ADDR_W-1:0] addr;
    logic [`MTIMER_DATA_W-1:0] wdata;
  } reg_req_t;

  // One result, 64 + 1 bits
  typedef struct packed {
    logic [`MTIMER_DATA_W-1:0] rdata;
    logic                      err;
  } reg_rsp_t;

  // ***********************************************************
  // Register map
  // ***********************************************************

  // mtime at the bottom of the window
  localparam logic [`MTIMER_ADDR_W-1:0] MTIME_OFFSET = 'h000;

  // Hart h compare register at MTIMECMP_BASE + 8*h
  localparam logic [`MTIMER_ADDR_W-1:0] MTIMECMP_BASE = 'h008;

endpackage

//--- verilog/mtimer_config.svh
`ifndef MTIMER_CONFIG_SVH
`define MTIMER_CONFIG_SVH

// ***********************************************************
// Machine timer build configuration
// ***********************************************************

// Harts served, one mtimecmp and one mtip each
`define MTIMER_NUM_HARTS 4

// Requesters in front of the register file
`define MTIMER_NUM_PORTS 2

// Byte address of a register access
`define MTIMER_ADDR_W 12

// Register width, mtime and mtimecmp are both this wide
`define MTIMER_DATA_W 64

`endif
